/* sim.f */
common/squeeze_pkg.sv
squeeze_layer/mac_unit.sv
squeeze_layer/weight_bias_rom.sv
squeeze_layer/squeeze_layer.sv
rtl/fmap_ram.sv
rtl/fmap_ram_arbiter.sv
rtl/ifm_streamer.sv
rtl/ofm_writer.sv
rtl/squeeze_top.sv
tests/squeeze_tb.sv

/* Makefile */
# Verilator simulation of the squeeze layer subsystem
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= squeeze_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/squeeze_tb.sv */
`timescale 1ns/100ps

module squeeze_tb import squeeze_pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// Test table and limits
	//////////////////////////////////////////////////////////////////////
	localparam int NUM_TESTS   = 7;
	localparam int HOST_READS  = 16;
	// Input map fill kinds
	localparam int FILL_ZERO   = 0;
	localparam int FILL_RAMP   = 1;
	localparam int FILL_RAND   = 2;
	localparam int FILL_NEG    = 3;
	localparam int FILL_POS    = 4;
	// Rough cycle budget per row, four times over for margin
	localparam int LOAD_CYCLES = 2*IFM_WORDS;
	localparam int RUN_CYCLES  = NUM_PIX*(CHIN+DSP_NO);
	localparam int READ_CYCLES = 3*NUM_PIX*DSP_NO;
	localparam int CYCLE_LIMIT = NUM_TESTS*(LOAD_CYCLES+RUN_CYCLES+READ_CYCLES)*4;

	typedef struct packed {
		logic [8*16-1:0] name;
		logic [2:0]      fill;
		logic            contend;
	} test_row_t;

	logic      clk;
	logic      rst;
	logic      start;
	ram_req_t  host_req;
	logic      host_gnt;
	logic [WIDTH-1:0] host_rdata;
	logic      finish;
	logic      finish_ack;

	test_row_t tests [NUM_TESTS];
	word_t     ifm_words [IFM_WORDS];
	int        cycle_cnt = 0;
	int        errors = 0;
	word_t     rd_word;
	word_t     exp_word;
	int        rd_addr;

	squeeze_top UUT (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.host_req   (host_req),
		.host_gnt   (host_gnt),
		.host_rdata (host_rdata),
		.finish     (finish),
		.finish_ack (finish_ack)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Failure handling and timeout
	//////////////////////////////////////////////////////////////////////
	task automatic stop_on_failure();
		errors = errors + 1;
		$display("Checks failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, finish never rose", CYCLE_LIMIT);
			stop_on_failure();
		end
	end

	task automatic check_word(input logic [8*16-1:0] name, input string what,
			input int addr, input word_t expected, input word_t actual);
		assert (actual === expected) else begin
			$display("mismatch %s %s addr %0d expected %0d actual %0d",
				name, what, addr, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_finish(input logic expected, input string when);
		assert (finish === expected) else begin
			$display("finish was %b %s, it should be %b", finish, when, expected);
			stop_on_failure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////
	// Dot product of one pixel with one kernel column, plus bias
	function automatic acc_t pixel_sum(input int p, input int k);
		acc_t sum;
		acc_t prod;
		sum = bias_table[k];
		for (int c = 0; c < CHIN; c++) begin
			prod = acc_t'(ifm_words[p*CHIN+c]) * acc_t'(weight_table[c][k]);
			sum  = sum + prod;
		end
		return sum;
	endfunction

	// Negative to zero, drop fraction bits, clip at the top
	function automatic word_t relu_clip(input acc_t sum);
		acc_t  shifted;
		acc_t  top;
		word_t result;
		top     = (acc_t'(1) <<< (WIDTH-1)) - acc_t'(1);
		shifted = sum >>> FRAC_BITS;
		if (sum < 0)
			result = '0;
		else if (shifted > top)
			result = top[WIDTH-1:0];
		else
			result = shifted[WIDTH-1:0];
		return result;
	endfunction

	// Activation for one input address
	function automatic word_t fill_value(input int kind, input int addr);
		word_t v;
		case (kind)
			FILL_RAMP: v = word_t'(1024 + 211*addr);
			FILL_RAND: v = word_t'(int'($urandom % 32768) - 16384);
			FILL_NEG:  v = word_t'(-16384 - int'($urandom % 16384));
			FILL_POS:  v = word_t'(16384 + int'($urandom % 16384));
			default:   v = '0;
		endcase
		return v;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Host port
	//////////////////////////////////////////////////////////////////////
	// Entered and left 2 ns after a rising edge
	task automatic host_write(input int addr, input word_t data);
		host_req.valid = 1'b1;
		host_req.we    = 1'b1;
		host_req.addr  = RAM_AW'(addr);
		host_req.wdata = data;
		// Grant is combinational, look mid-cycle
		// Only the host uses the RAM during the load
		@(negedge clk);
		assert (host_gnt === 1'b1) else begin
			$display("host write to addr %0d got no grant while the RAM was idle", addr);
			stop_on_failure();
		end
		@(posedge clk);
		#2;
		host_req = '0;
	endtask

	task automatic host_read(input int addr, output word_t data);
		host_req.valid = 1'b1;
		host_req.we    = 1'b0;
		host_req.addr  = RAM_AW'(addr);
		host_req.wdata = '0;
		@(negedge clk);
		while (host_gnt !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		#2;
		host_req = '0;
		// One cycle read latency
		@(negedge clk);
		data = host_rdata;
		@(posedge clk);
		#2;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		rst        = 1'b1;
		start      = 1'b0;
		finish_ack = 1'b0;
		host_req   = '0;
		void'($urandom(84));

		tests[0] = '{name: "zero_input",     fill: 3'(FILL_ZERO), contend: 1'b0};
		tests[1] = '{name: "ramp_input",     fill: 3'(FILL_RAMP), contend: 1'b0};
		tests[2] = '{name: "random_input",   fill: 3'(FILL_RAND), contend: 1'b0};
		tests[3] = '{name: "neg_large",      fill: 3'(FILL_NEG),  contend: 1'b0};
		tests[4] = '{name: "pos_saturate",   fill: 3'(FILL_POS),  contend: 1'b0};
		tests[5] = '{name: "random_contend", fill: 3'(FILL_RAND), contend: 1'b1};
		tests[6] = '{name: "pos_contend",    fill: 3'(FILL_POS),  contend: 1'b1};

		for (int t = 0; t < NUM_TESTS; t++) begin
			apply_reset();
			check_finish(1'b0, "after reset");

			// Input map through the host port
			for (int a = 0; a < IFM_WORDS; a++) begin
				ifm_words[a] = fill_value(int'(tests[t].fill), a);
				host_write(IFM_BASE + a, ifm_words[a]);
			end

			// Start pulse
			start = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
			check_finish(1'b0, "right after start");

			// Host reads steal RAM slots from the streamer
			if (tests[t].contend) begin
				for (int i = 0; i < HOST_READS; i++) begin
					rd_addr = int'($urandom % IFM_WORDS);
					check_finish(1'b0, "during the run");
					host_read(IFM_BASE + rd_addr, rd_word);
					check_word(tests[t].name, "host read", IFM_BASE + rd_addr,
						ifm_words[rd_addr], rd_word);
				end
			end

			// Timeout block ends a hung run
			@(negedge clk);
			while (finish !== 1'b1)
				@(negedge clk);
			@(posedge clk);
			#2;
			check_finish(1'b1, "after the last store");

			// Output map readback against the model
			for (int p = 0; p < NUM_PIX; p++) begin
				for (int k = 0; k < DSP_NO; k++) begin
					exp_word = relu_clip(pixel_sum(p, k));
					host_read(OFM_BASE + p*DSP_NO + k, rd_word);
					check_word(tests[t].name, "ofm", OFM_BASE + p*DSP_NO + k,
						exp_word, rd_word);
				end
			end

			// Ack drops finish
			finish_ack = 1'b1;
			@(posedge clk);
			#2;
			finish_ack = 1'b0;
			@(negedge clk);
			check_finish(1'b0, "after finish_ack");
			@(posedge clk);
			#2;
		end

		if (errors == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1);
		end
	end

endmodule

/* rtl/squeeze_top.sv */
`timescale 1ns/100ps

module squeeze_top import squeeze_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  ram_req_t         host_req,
	output logic             host_gnt,
	output logic [WIDTH-1:0] host_rdata,
	output logic             finish,
	input  logic             finish_ack
);

	ram_req_t         wr_req;
	ram_req_t         strm_req;
	ram_req_t         ram_req;
	logic             wr_gnt;
	logic             strm_gnt;
	logic [WIDTH-1:0] ram_rdata;
	logic             layer_en;
	logic [WIDTH-1:0] ifm;
	logic             sample;
	ofm_vec_t         ofm;
	logic             ram_feedback;

	//////////////////////////////////////////////////////////////////////
	// Shared feature-map RAM
	//////////////////////////////////////////////////////////////////////
	fmap_ram u_ram (
		.clk   (clk),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

	// Read data goes to every reader
	assign host_rdata = ram_rdata;

	fmap_ram_arbiter u_arb (
		.clk      (clk),
		.rst      (rst),
		.wr_req   (wr_req),
		.host_req (host_req),
		.strm_req (strm_req),
		.wr_gnt   (wr_gnt),
		.host_gnt (host_gnt),
		.strm_gnt (strm_gnt),
		.ram_req  (ram_req)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////
	ifm_streamer u_strm (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.gnt      (strm_gnt),
		.rdata    (ram_rdata),
		.req      (strm_req),
		.layer_en (layer_en),
		.ifm      (ifm)
	);

	squeeze_layer u_layer (
		.clk          (clk),
		.rst          (rst),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.finish_ack   (finish_ack),
		.sample       (sample),
		.ofm          (ofm),
		.finish       (finish)
	);

	ofm_writer u_wr (
		.clk          (clk),
		.rst          (rst),
		.sample       (sample),
		.ofm          (ofm),
		.gnt          (wr_gnt),
		.req          (wr_req),
		.ram_feedback (ram_feedback)
	);

endmodule

/* rtl/ofm_writer.sv */
`timescale 1ns/100ps

module ofm_writer import squeeze_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     sample,
	input  ofm_vec_t ofm,
	input  logic     gnt,
	output ram_req_t req,
	output logic     ram_feedback
);

	ofm_vec_t          ofm_q;
	logic              busy;
	logic [DSP_AW-1:0] word;
	logic [PIX_AW-1:0] pix;

	// Output vector held for the store
	always_ff @(posedge clk) begin
		if (sample)
			ofm_q <= ofm;
	end

	//////////////////////////////////////////////////////////////////////
	// Store sequencer
	//////////////////////////////////////////////////////////////////////
	// Top priority, so one word per cycle after sample
	always_ff @(posedge clk) begin
		if (rst) begin
			busy         <= 1'b0;
			word         <= '0;
			pix          <= '0;
			ram_feedback <= 1'b0;
		end else begin
			ram_feedback <= 1'b0;
			if (sample) begin
				busy <= 1'b1;
				word <= '0;
			end else if (busy && gnt) begin
				word <= word + 1'b1;
				if (word == DSP_AW'(DSP_NO-1)) begin
					busy <= 1'b0;
					pix  <= pix + 1'b1;
					// Whole output map now in RAM
					if (pix == PIX_AW'(NUM_PIX-1))
						ram_feedback <= 1'b1;
				end
			end
		end
	end

	always_comb begin
		req.valid = busy;
		req.we    = 1'b1;
		req.addr  = RAM_AW'(OFM_BASE) + RAM_AW'(pix) * RAM_AW'(DSP_NO) + RAM_AW'(word);
		req.wdata = ofm_q[word];
	end

	// Pixels arrive at least CHIN beats apart
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		sample |-> !busy);

endmodule

/* rtl/ifm_streamer.sv */
`timescale 1ns/100ps

module ifm_streamer import squeeze_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic             gnt,
	input  logic [WIDTH-1:0] rdata,
	output ram_req_t         req,
	output logic             layer_en,
	output logic [WIDTH-1:0] ifm
);

	logic              running;
	logic [BEAT_W-1:0] rd_cnt;
	logic              pend;

	//////////////////////////////////////////////////////////////////////
	// Read address counter
	//////////////////////////////////////////////////////////////////////
	// Pixel-major, channel-minor order matches the map layout
	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			rd_cnt  <= '0;
			pend    <= 1'b0;
		end else begin
			// Granted read returns next cycle
			pend <= req.valid && gnt;
			if (start) begin
				running <= 1'b1;
				rd_cnt  <= '0;
			end else if (running && gnt) begin
				if (rd_cnt == BEAT_W'(IFM_WORDS-1))
					running <= 1'b0;
				rd_cnt <= rd_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		req.valid = running;
		req.we    = 1'b0;
		req.addr  = RAM_AW'(IFM_BASE) + RAM_AW'(rd_cnt);
		req.wdata = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Beats into the layer
	//////////////////////////////////////////////////////////////////////
	// Only the cycle after our own grant carries our data
	assign layer_en = pend;
	assign ifm      = rdata;

endmodule

/* rtl/fmap_ram_arbiter.sv */
`timescale 1ns/100ps

module fmap_ram_arbiter import squeeze_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  ram_req_t wr_req,
	input  ram_req_t host_req,
	input  ram_req_t strm_req,
	output logic     wr_gnt,
	output logic     host_gnt,
	output logic     strm_gnt,
	output ram_req_t ram_req
);

	//////////////////////////////////////////////////////////////////////
	// Fixed priority
	//////////////////////////////////////////////////////////////////////
	// Writer first so a pixel store never stalls
	// Host next, streamer takes what is left
	always_comb begin
		wr_gnt   = wr_req.valid;
		host_gnt = host_req.valid && !wr_req.valid;
		strm_gnt = strm_req.valid && !wr_req.valid && !host_req.valid;
	end

	// Winner goes to the RAM
	// Idle cycle forwards the streamer slot with valid low
	always_comb begin
		if (wr_gnt)
			ram_req = wr_req;
		else if (host_gnt)
			ram_req = host_req;
		else
			ram_req = strm_req;
	end

	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		$onehot0({wr_gnt, host_gnt, strm_gnt}));

	// Losing streamer keeps its read in place
	a_strm_hold: assert property (@(posedge clk) disable iff (rst)
		strm_req.valid && !strm_gnt |=> $stable(strm_req));

endmodule

/* rtl/fmap_ram.sv */
`timescale 1ns/100ps

module fmap_ram import squeeze_pkg::*; (
	input  logic             clk,
	input  ram_req_t         req,
	output logic [WIDTH-1:0] rdata
);

	logic [WIDTH-1:0] mem [RAM_DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Single port, write or read per cycle
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (req.valid) begin
			if (req.we)
				mem[req.addr] <= req.wdata;
			else
				// Read data on the next cycle
				rdata <= mem[req.addr];
		end
	end

endmodule

/* squeeze_layer/squeeze_layer.sv */
`timescale 1ns/100ps

module squeeze_layer import squeeze_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             layer_en,
	input  logic [WIDTH-1:0] ifm,
	input  logic             ram_feedback,
	input  logic             finish_ack,
	output logic             sample,
	output ofm_vec_t         ofm,
	output logic             finish
);

	logic             en_q;
	logic             en_qq;
	word_t            ifm_q;
	word_t            ifm_qq;
	logic [CH_AW-1:0] rom_addr;
	logic             rom_clr;
	logic             clr_pulse;
	ker_vec_t         kernels;
	ker_vec_t         kernel_q;
	bias_vec_t        bias;
	acc_t             acc [DSP_NO];
	logic [PIX_AW-1:0] pix_cnt;
	logic             layer_end;
	logic             stored;
	logic             acked;
	logic [BEAT_W-1:0] beat_cnt;

	//////////////////////////////////////////////////////////////////////
	// Input registers
	//////////////////////////////////////////////////////////////////////
	// Two stages so a beat meets its kernel column at the MACs
	always_ff @(posedge clk) begin
		if (rst) begin
			en_q  <= 1'b0;
			en_qq <= 1'b0;
		end else begin
			en_q  <= layer_en;
			en_qq <= en_q;
		end
	end

	always_ff @(posedge clk) begin
		ifm_q  <= ifm;
		ifm_qq <= ifm_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Beat counter and clear pulse
	//////////////////////////////////////////////////////////////////////
	// ROM address follows the channel of the beat in stage one
	always_ff @(posedge clk) begin
		if (rst) begin
			rom_addr  <= '0;
			rom_clr   <= 1'b0;
			clr_pulse <= 1'b0;
		end else begin
			// Last channel seen, close the pixel
			rom_clr   <= en_q && (rom_addr == CH_AW'(CHIN-1));
			clr_pulse <= rom_clr;
			if (en_q) begin
				if (rom_addr == CH_AW'(CHIN-1))
					rom_addr <= '0;
				else
					rom_addr <= rom_addr + 1'b1;
			end
		end
	end

	weight_bias_rom u_rom (
		.addr    (rom_addr),
		.kernels (kernels),
		.bias    (bias)
	);

	// Kernel column lines up with ifm_qq
	always_ff @(posedge clk) begin
		kernel_q <= kernels;
	end

	//////////////////////////////////////////////////////////////////////
	// MAC array
	//////////////////////////////////////////////////////////////////////
	for (genvar i = 0; i < DSP_NO; i++) begin : g_mac
		mac_unit u_mac (
			.clk (clk),
			.rst (rst),
			.en  (en_qq),
			.clr (clr_pulse),
			.pix (ifm_qq),
			.ker (kernel_q[i]),
			.acc (acc[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Bias, ReLU and requantization
	//////////////////////////////////////////////////////////////////////
	// acc still holds the finished sum while clr_pulse is high
	always_ff @(posedge clk) begin
		if (clr_pulse) begin
			for (int k = 0; k < DSP_NO; k++) begin
				ofm[k] <= requant(acc[k] + bias[k]);
			end
		end
	end

	// Strobe while fresh ofm is on the outputs
	always_ff @(posedge clk) begin
		if (rst)
			sample <= 1'b0;
		else
			sample <= clr_pulse;
	end

	//////////////////////////////////////////////////////////////////////
	// Pixel timer and finish
	//////////////////////////////////////////////////////////////////////
	assign layer_end = (pix_cnt == PIX_AW'(NUM_PIX));

	always_ff @(posedge clk) begin
		if (rst) begin
			pix_cnt <= '0;
			stored  <= 1'b0;
			acked   <= 1'b0;
		end else begin
			if (clr_pulse && !layer_end)
				pix_cnt <= pix_cnt + 1'b1;
			// Writer done with the last pixel
			if (ram_feedback && layer_end)
				stored <= 1'b1;
			// Ack masks finish until the next reset
			if (finish_ack)
				acked <= 1'b1;
		end
	end

	assign finish = stored && !acked;

	// Total beats since reset, saturating
	always_ff @(posedge clk) begin
		if (rst)
			beat_cnt <= '0;
		else if (layer_en && beat_cnt != BEAT_W'(IFM_WORDS))
			beat_cnt <= beat_cnt + 1'b1;
	end

	a_beat_limit: assert property (@(posedge clk) disable iff (rst)
		layer_en |-> beat_cnt < BEAT_W'(IFM_WORDS));

	a_sample_pulse: assert property (@(posedge clk) disable iff (rst)
		sample |=> !sample);

endmodule

/* squeeze_layer/weight_bias_rom.sv */
`timescale 1ns/100ps

module weight_bias_rom import squeeze_pkg::*; (
	input  logic [CH_AW-1:0] addr,
	output ker_vec_t         kernels,
	output bias_vec_t        bias
);

	//////////////////////////////////////////////////////////////////////
	// Kernel column lookup
	//////////////////////////////////////////////////////////////////////
	// One column per input channel, one word per MAC lane
	always_comb begin
		kernels = weight_table[addr];
	end

	//////////////////////////////////////////////////////////////////////
	// Bias vector
	//////////////////////////////////////////////////////////////////////
	// Same for every pixel
	always_comb begin
		bias = bias_table;
	end

endmodule

/* squeeze_layer/mac_unit.sv */
`timescale 1ns/100ps

module mac_unit import squeeze_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  en,
	input  logic  clr,
	input  word_t pix,
	input  word_t ker,
	output acc_t  acc
);

	acc_t prod;

	// Full-width signed product
	assign prod = pix * ker;

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (clr) begin
			// New pixel starts here
			// Gap beat on the boundary loads zero
			acc <= en ? prod : '0;
		end else if (en) begin
			acc <= acc + prod;
		end
	end

endmodule

/* common/squeeze_pkg.sv */
package squeeze_pkg;

	//////////////////////////////////////////////////////////////////////
	// Layer sizes
	//////////////////////////////////////////////////////////////////////
	localparam int WIDTH     = 16;
	localparam int ACC_WIDTH = 2*WIDTH;
	// Q1.14 activations and weights
	localparam int FRAC_BITS = 14;
	localparam int CHIN      = 8;
	// One MAC lane per output channel
	localparam int DSP_NO    = 4;
	localparam int WOUT      = 3;
	localparam int NUM_PIX   = WOUT*WOUT;

	// Counter widths
	localparam int CH_AW     = $clog2(CHIN);
	localparam int DSP_AW    = $clog2(DSP_NO);
	localparam int PIX_AW    = $clog2(NUM_PIX+1);
	localparam int IFM_WORDS = NUM_PIX*CHIN;
	localparam int BEAT_W    = $clog2(IFM_WORDS+1);

	//////////////////////////////////////////////////////////////////////
	// Feature-map RAM layout
	//////////////////////////////////////////////////////////////////////
	localparam int RAM_DEPTH = 128;
	localparam int RAM_AW    = $clog2(RAM_DEPTH);
	// Input pixel p channel c at IFM_BASE + p*CHIN + c
	localparam int IFM_BASE  = 0;
	// Output pixel p channel k at OFM_BASE + p*DSP_NO + k
	// 36 output words must fit below RAM_DEPTH
	localparam int OFM_BASE  = 80;

	typedef logic signed [WIDTH-1:0] word_t;
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef word_t [0:DSP_NO-1] ofm_vec_t;
	typedef word_t [0:DSP_NO-1] ker_vec_t;
	typedef acc_t [0:DSP_NO-1] bias_vec_t;

	typedef struct packed {
		logic              valid;
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [WIDTH-1:0]  wdata;
	} ram_req_t;

	// Largest positive activation
	localparam acc_t ACT_MAX = acc_t'(2**(WIDTH-1)-1);

	//////////////////////////////////////////////////////////////////////
	// Constant kernels and biases
	//////////////////////////////////////////////////////////////////////
	// One row per input channel, output channels 0..3 left to right
	// Lane 0 all positive so big inputs saturate, lane 2 mostly negative
	localparam ker_vec_t weight_table [CHIN] = '{
		'{ 4096,  2048, -3072,   512},
		'{ 3072, -1024, -2048,  1536},
		'{ 5120,  3072,  1024,  -768},
		'{ 2048, -2048, -4096,   256},
		'{ 4096,  1024, -1024,  2048},
		'{ 6144,   512, -2048,  -256},
		'{ 3072,  -512,   512,  1024},
		'{ 2048,  4096, -3072,   768}
	};

	// Bias in product scale, 28 fractional bits
	// Lane 1 negative so an all-zero map gives 0 there
	localparam bias_vec_t bias_table = '{
		268435456,
		-134217728,
		67108864,
		0
	};

	// ReLU, drop fraction, clip to the activation range
	function automatic word_t requant(input acc_t sum);
		acc_t shifted;
		shifted = sum >>> FRAC_BITS;
		if (sum < 0)
			return '0;
		else if (shifted > ACT_MAX)
			return ACT_MAX[WIDTH-1:0];
		else
			return shifted[WIDTH-1:0];
	endfunction

endpackage
